// File: design/oric_tape_pkg.sv
////////////////////
// Oric tape and audio package
// Widths, download index, tape timing and mixer levels
////////////////////
package oric_tape_pkg;

	// Tape cache
	localparam int tape_addr_w = 16;
	localparam int tape_depth = 2 ** tape_addr_w;

	typedef logic [tape_addr_w-1:0] tape_addr_t;
	typedef logic [7:0] tape_byte_t;
	typedef logic [7:0] dl_index_t;

	// Download index of a tape file
	localparam dl_index_t tape_index = 8'd1;

	// Clock cycles per serial tape bit
	localparam int bit_cycles = 4;
	localparam int bit_cnt_w = $clog2(bit_cycles);
	typedef logic [bit_cnt_w-1:0] bit_cnt_t;

	// Sound generator and output words
	typedef logic [11:0] psg_chan_t;
	typedef logic [13:0] psg_mono_t;
	typedef logic [15:0] audio_word_t;
	typedef logic [10:0] tape_level_t;
	typedef logic [14:0] mix_sum_t;

	// Tape volume codes, 2 and 3 both select high
	typedef logic [1:0] tape_volume_t;
	localparam tape_volume_t vol_mute = 2'd0;
	localparam tape_volume_t vol_low = 2'd1;
	localparam tape_level_t tape_level_low = 11'd512;
	localparam tape_level_t tape_level_high = 11'd1024;

	// Stereo codes, 2 and 3 both select ACB
	typedef logic [1:0] stereo_mode_t;
	localparam stereo_mode_t stereo_mono = 2'd0;
	localparam stereo_mode_t stereo_abc = 2'd1;

endpackage

// File: design/tape_store_if.sv
////////////////////
// Tape store interface
// Cache read port and tape state, loader to player
////////////////////
interface tape_store_if;

	oric_tape_pkg::tape_addr_t read_addr;
	// Byte at read_addr, one cycle later
	oric_tape_pkg::tape_byte_t read_data;
	oric_tape_pkg::tape_addr_t last_addr;
	logic loaded;
	// Level, high during a tape download or rewind
	logic restart;

	modport store (
		input read_addr,
		output read_data,
		output last_addr,
		output loaded,
		output restart
	);

	modport player (
		output read_addr,
		input read_data,
		input last_addr,
		input loaded,
		input restart
	);

endinterface

// File: design/tape_loader.sv
////////////////////
// Tape loader
// Stores tape downloads in the 64 KiB cache,
// tracks the end address and the loaded state
////////////////////
module tape_loader (
	input logic clk_sys,
	input logic reset,
	input logic dl_wr,
	input oric_tape_pkg::tape_addr_t dl_addr,
	input oric_tape_pkg::tape_byte_t dl_data,
	input logic dl_active,
	input oric_tape_pkg::dl_index_t dl_index,
	input logic tape_rewind,
	tape_store_if.store store
);

	// Tape cache, no reset on the array
	oric_tape_pkg::tape_byte_t cache [0:oric_tape_pkg::tape_depth-1];

	logic is_tape;
	logic tape_wr;
	logic dl_active_d;
	logic dl_end;

	// Any other index, such as the BIOS store, is ignored
	assign is_tape = (dl_index == oric_tape_pkg::tape_index);
	assign tape_wr = dl_wr && is_tape;

	// Falling edge of the download level
	assign dl_end = dl_active_d && !dl_active;

	////////////////////
	// Cache write and read ports
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (tape_wr) begin
			cache[dl_addr] <= dl_data;
		end
	end

	// Registered read, data follows the address by one cycle
	always_ff @(posedge clk_sys) begin
		store.read_data <= cache[store.read_addr];
	end

	////////////////////
	// Download state
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_d <= 1'b0;
		end else begin
			dl_active_d <= dl_active;
		end
	end

	// Last written address marks the end of the tape
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			store.last_addr <= '0;
		end else if (tape_wr) begin
			store.last_addr <= dl_addr;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			store.loaded <= 1'b0;
		end else if (dl_active && is_tape) begin
			// New tape coming in, old one is gone
			store.loaded <= 1'b0;
		end else if (dl_end && is_tape) begin
			store.loaded <= 1'b1;
		end
	end

	// Playback restarts on rewind or while a new tape arrives
	assign store.restart = (dl_active && is_tape) || tape_rewind;

endmodule

// File: design/tape_player.sv
////////////////////
// Tape player
// Reads the cache and shifts each byte out as
// a serial tape bit, MSB first, under motor control
////////////////////
module tape_player (
	input logic clk_sys,
	input logic reset,
	input logic tape_motor,
	tape_store_if.player store,
	output logic tape_bit
);

	oric_tape_pkg::tape_addr_t read_addr;
	oric_tape_pkg::tape_byte_t shift_reg;
	logic [2:0] bit_idx;
	oric_tape_pkg::bit_cnt_t bit_count;
	// Address 0 issued, its data arrives next cycle
	logic primed;
	// At least one byte taken from the cache
	logic have_byte;
	logic done;
	logic enable;
	logic byte_boundary;
	logic end_of_tape;

	assign enable = tape_motor && store.loaded;

	assign byte_boundary = !have_byte || (bit_idx == 3'd7);

	// read_addr already points past the byte just sent
	assign end_of_tape = have_byte &&
		(read_addr == oric_tape_pkg::tape_addr_t'(store.last_addr + 1'b1));

	assign store.read_addr = read_addr;

	////////////////////
	// Bit sequencer
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset || store.restart) begin
			read_addr <= '0;
			bit_idx <= '0;
			bit_count <= '0;
			primed <= 1'b0;
			have_byte <= 1'b0;
			done <= 1'b0;
			tape_bit <= 1'b0;
		end else if (enable && !done) begin
			if (!primed) begin
				// First enabled cycle, address 0 is on the bus
				primed <= 1'b1;
			end else if (bit_count != '0) begin
				// Hold the current bit
				bit_count <= bit_count - 1'b1;
			end else if (byte_boundary) begin
				if (end_of_tape) begin
					done <= 1'b1;
					tape_bit <= 1'b0;
				end else begin
					// Next byte is already waiting on read_data
					shift_reg <= store.read_data;
					tape_bit <= store.read_data[7];
					bit_idx <= '0;
					bit_count <= oric_tape_pkg::bit_cnt_t'(oric_tape_pkg::bit_cycles - 1);
					read_addr <= read_addr + 1'b1;
					have_byte <= 1'b1;
				end
			end else begin
				shift_reg <= {shift_reg[6:0], 1'b0};
				tape_bit <= shift_reg[6];
				bit_idx <= bit_idx + 1'b1;
				bit_count <= oric_tape_pkg::bit_cnt_t'(oric_tape_pkg::bit_cycles - 1);
			end
		end
	end

endmodule

// File: design/audio_mixer.sv
////////////////////
// Audio mixer
// Sound channels plus tape level into
// registered left and right words
////////////////////
module audio_mixer (
	input logic clk_sys,
	input logic reset,
	input logic tape_bit,
	input oric_tape_pkg::tape_volume_t tape_volume,
	input oric_tape_pkg::stereo_mode_t stereo_mode,
	input oric_tape_pkg::psg_chan_t psg_a,
	input oric_tape_pkg::psg_chan_t psg_b,
	input oric_tape_pkg::psg_chan_t psg_c,
	input oric_tape_pkg::psg_mono_t psg_mono,
	output oric_tape_pkg::audio_word_t audio_l,
	output oric_tape_pkg::audio_word_t audio_r
);

	oric_tape_pkg::tape_level_t tape_level;
	oric_tape_pkg::mix_sum_t sum_mono;
	oric_tape_pkg::mix_sum_t sum_ab;
	oric_tape_pkg::mix_sum_t sum_ac;
	oric_tape_pkg::mix_sum_t sum_bc;
	oric_tape_pkg::mix_sum_t sum_l;
	oric_tape_pkg::mix_sum_t sum_r;

	////////////////////
	// Tape level
	////////////////////

	always_comb begin
		if (!tape_bit || tape_volume == oric_tape_pkg::vol_mute) begin
			tape_level = '0;
		end else if (tape_volume == oric_tape_pkg::vol_low) begin
			tape_level = oric_tape_pkg::tape_level_low;
		end else begin
			tape_level = oric_tape_pkg::tape_level_high;
		end
	end

	////////////////////
	// Channel sums
	////////////////////

	// Widened to 15 bits so no sum can overflow
	assign sum_mono = oric_tape_pkg::mix_sum_t'(psg_mono)
		+ oric_tape_pkg::mix_sum_t'(tape_level);
	assign sum_ab = oric_tape_pkg::mix_sum_t'(psg_a) + oric_tape_pkg::mix_sum_t'(psg_b)
		+ oric_tape_pkg::mix_sum_t'(tape_level);
	assign sum_ac = oric_tape_pkg::mix_sum_t'(psg_a) + oric_tape_pkg::mix_sum_t'(psg_c)
		+ oric_tape_pkg::mix_sum_t'(tape_level);
	assign sum_bc = oric_tape_pkg::mix_sum_t'(psg_b) + oric_tape_pkg::mix_sum_t'(psg_c)
		+ oric_tape_pkg::mix_sum_t'(tape_level);

	always_comb begin
		if (stereo_mode == oric_tape_pkg::stereo_mono) begin
			sum_l = sum_mono;
			sum_r = sum_mono;
		end else if (stereo_mode == oric_tape_pkg::stereo_abc) begin
			sum_l = sum_ab;
			sum_r = sum_bc;
		end else begin
			// ACB, right side same as ABC
			sum_l = sum_ac;
			sum_r = sum_bc;
		end
	end

	// Output words, shifted left once
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= {sum_l, 1'b0};
			audio_r <= {sum_r, 1'b0};
		end
	end

endmodule

// File: design/oric_tape_audio.sv
////////////////////
// Oric tape and audio top level
// Tape loader, tape player and audio mixer
////////////////////
module oric_tape_audio (
	input logic clk_sys,
	input logic reset,

	// File download
	input logic dl_wr,
	input oric_tape_pkg::tape_addr_t dl_addr,
	input oric_tape_pkg::tape_byte_t dl_data,
	input logic dl_active,
	input oric_tape_pkg::dl_index_t dl_index,

	// Cassette control
	input logic tape_motor,
	input logic tape_rewind,

	// Audio settings and sound generator
	input oric_tape_pkg::tape_volume_t tape_volume,
	input oric_tape_pkg::stereo_mode_t stereo_mode,
	input oric_tape_pkg::psg_chan_t psg_a,
	input oric_tape_pkg::psg_chan_t psg_b,
	input oric_tape_pkg::psg_chan_t psg_c,
	input oric_tape_pkg::psg_mono_t psg_mono,

	output logic tape_loaded,
	output logic tape_bit,
	output oric_tape_pkg::audio_word_t audio_l,
	output oric_tape_pkg::audio_word_t audio_r
);

	tape_store_if store ();

	tape_loader loader_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.dl_wr(dl_wr),
		.dl_addr(dl_addr),
		.dl_data(dl_data),
		.dl_active(dl_active),
		.dl_index(dl_index),
		.tape_rewind(tape_rewind),
		.store(store.store)
	);

	tape_player player_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.tape_motor(tape_motor),
		.store(store.player),
		.tape_bit(tape_bit)
	);

	// Tape bit also feeds the mixer
	audio_mixer mixer_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.tape_bit(tape_bit),
		.tape_volume(tape_volume),
		.stereo_mode(stereo_mode),
		.psg_a(psg_a),
		.psg_b(psg_b),
		.psg_c(psg_c),
		.psg_mono(psg_mono),
		.audio_l(audio_l),
		.audio_r(audio_r)
	);

	assign tape_loaded = store.loaded;

endmodule

// File: bench/oric_tape_audio_assertions.sv
////////////////////
// Tape and audio checks
// Concurrent properties on the top level ports
////////////////////
module oric_tape_audio_assertions (
	input logic clk_sys,
	input logic reset,
	input logic dl_active,
	input logic tape_loaded,
	input logic tape_bit,
	input oric_tape_pkg::audio_word_t audio_l,
	input oric_tape_pkg::audio_word_t audio_r
);

	timeunit 1ns;
	timeprecision 1ps;

	// No tape, no tape signal
	bit_needs_tape: assert property (@(posedge clk_sys) disable iff (reset)
		!tape_loaded |-> !tape_bit)
		else $error("tape_bit high without a loaded tape");

	// Outputs are shifted left once
	audio_l_even: assert property (@(posedge clk_sys) disable iff (reset)
		audio_l[0] == 1'b0)
		else $error("audio_l bit 0 set");

	audio_r_even: assert property (@(posedge clk_sys) disable iff (reset)
		audio_r[0] == 1'b0)
		else $error("audio_r bit 0 set");

	loaded_holds: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(tape_loaded) |-> ($past(dl_active) || $past(reset)))
		else $error("tape_loaded fell outside a download");

endmodule

bind oric_tape_audio oric_tape_audio_assertions asrt_i (.*);

// File: bench/oric_tape_audio_tb.sv
////////////////////
// Testbench for the Oric tape and audio core
// Download, playback, pause, rewind and mixer table
////////////////////
module oric_tape_audio_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_bytes = 24;
	localparam int n_bits = n_bytes * 8;
	localparam int n_rows = 16;
	localparam int max_pause = 20;
	// Cycle budget of each phase, doubled for the watchdog
	localparam int dl_len = 2 * (n_bytes + 4);
	localparam int play_len = 2 * (4 * n_bits + 16 + max_pause);
	localparam int table_len = n_rows * 66 + 8;
	localparam int limit_cycles = 2 * (dl_len + play_len + table_len);

	typedef struct {
		oric_tape_pkg::stereo_mode_t mode;
		oric_tape_pkg::tape_volume_t vol;
		logic tbit;
		oric_tape_pkg::psg_chan_t a, b, c;
		oric_tape_pkg::psg_mono_t mono;
		oric_tape_pkg::audio_word_t exp_l, exp_r;
	} mix_row_t;

	logic clk_sys = 1'b0;
	logic reset;
	logic dl_wr, dl_active, tape_motor, tape_rewind;
	oric_tape_pkg::tape_addr_t dl_addr;
	oric_tape_pkg::tape_byte_t dl_data;
	oric_tape_pkg::dl_index_t dl_index;
	oric_tape_pkg::tape_volume_t tape_volume;
	oric_tape_pkg::stereo_mode_t stereo_mode;
	oric_tape_pkg::psg_chan_t psg_a, psg_b, psg_c;
	oric_tape_pkg::psg_mono_t psg_mono;
	logic tape_loaded, tape_bit;
	oric_tape_pkg::audio_word_t audio_l, audio_r;

	oric_tape_pkg::tape_byte_t tape_data [n_bytes];
	oric_tape_pkg::tape_byte_t other_data [n_bytes];
	mix_row_t rows [n_rows];
	int n_checks = 0;
	int n_errors = 0;

	oric_tape_audio dut_i (.*);

	always #50 clk_sys = ~clk_sys;

	// Watchdog
	initial begin
		#(limit_cycles * 100);
		$display("Watchdog expired, simulation did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	task automatic check_word(input string name, input oric_tape_pkg::audio_word_t exp,
		input oric_tape_pkg::audio_word_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Fail at %0d ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Fail at %0d ns: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("%s finished with %0d errors", name, n_errors - errors_before);
	endtask

	// Mixer rule, sums kept to 15 bits then shifted left once
	function automatic oric_tape_pkg::audio_word_t mix_ref(input int x, input int y,
		input int level);
		int sum;
		sum = (x + y + level) & 32'h7fff;
		return oric_tape_pkg::audio_word_t'(sum << 1);
	endfunction

	task automatic build_row(input int i);
		int level;
		rows[i].mode = oric_tape_pkg::stereo_mode_t'(i >> 2);
		rows[i].vol = oric_tape_pkg::tape_volume_t'(i & 3);
		rows[i].tbit = 1'(((i >> 2) & 1) ^ (i & 1));
		rows[i].a = oric_tape_pkg::psg_chan_t'($urandom);
		rows[i].b = oric_tape_pkg::psg_chan_t'($urandom);
		rows[i].c = oric_tape_pkg::psg_chan_t'($urandom);
		rows[i].mono = oric_tape_pkg::psg_mono_t'($urandom);
		level = !rows[i].tbit || rows[i].vol == 0 ? 0 : (rows[i].vol == 1 ? 512 : 1024);
		if (rows[i].mode == 0) begin
			rows[i].exp_l = mix_ref(rows[i].mono, 0, level);
			rows[i].exp_r = rows[i].exp_l;
		end else begin
			rows[i].exp_l = mix_ref(rows[i].a, rows[i].mode == 1 ? rows[i].b : rows[i].c,
				level);
			rows[i].exp_r = mix_ref(rows[i].b, rows[i].c, level);
		end
	endtask

	task automatic run_download(input oric_tape_pkg::dl_index_t idx, input logic is_tape);
		@(posedge clk_sys);
		dl_active <= 1'b1;
		dl_index <= idx;
		for (int i = 0; i < n_bytes; i++) begin
			@(posedge clk_sys);
			dl_wr <= 1'b1;
			dl_addr <= oric_tape_pkg::tape_addr_t'(i);
			dl_data <= is_tape ? tape_data[i] : other_data[i];
		end
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		dl_active <= 1'b0;
		@(negedge clk_sys);
		check_bit("tape_loaded", 1'b0, tape_loaded);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_bit("tape_loaded", is_tape, tape_loaded);
	endtask

	// Bit k is sampled 4 + 4k cycles after the motor edge, later by the pause
	task automatic play_stream(input int pause_at, input int pause_len);
		int k;
		int drop;
		int target;
		k = 0;
		drop = 4 * pause_at + 1;
		@(posedge clk_sys);
		tape_motor <= 1'b1;
		for (int c = 1; c <= 4 * n_bits + pause_len + 10; c++) begin
			@(posedge clk_sys);
			if (pause_len > 0 && c == drop) tape_motor <= 1'b0;
			if (pause_len > 0 && c == drop + pause_len) tape_motor <= 1'b1;
			@(negedge clk_sys);
			target = 4 + 4 * k + (k >= pause_at ? pause_len : 0);
			if (k < n_bits && c == target) begin
				check_bit("tape_bit", tape_data[k / 8][7 - k % 8], tape_bit);
				k++;
			end else if (c >= 4 * n_bits + 2 + pause_len) begin
				check_bit("tape_bit", 1'b0, tape_bit);
			end
		end
	endtask

	task automatic rewind_tape();
		@(posedge clk_sys);
		tape_motor <= 1'b0;
		tape_rewind <= 1'b1;
		@(posedge clk_sys);
		tape_rewind <= 1'b0;
		@(negedge clk_sys);
		check_bit("tape_bit", 1'b0, tape_bit);
	endtask

	task automatic apply_row(input int i);
		bit seen;
		seen = 1'b0;
		for (int t = 0; t < 64 && !seen; t++) begin
			@(posedge clk_sys);
			stereo_mode <= rows[i].mode;
			tape_volume <= rows[i].vol;
			psg_a <= rows[i].a;
			psg_b <= rows[i].b;
			psg_c <= rows[i].c;
			psg_mono <= rows[i].mono;
			@(negedge clk_sys);
			seen = (tape_bit === rows[i].tbit);
		end
		if (!seen) begin
			n_errors++;
			$display("Row %0d: tape_bit never reached the wanted level", i);
		end
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_word("audio_l", rows[i].exp_l, audio_l);
		check_word("audio_r", rows[i].exp_r, audio_r);
	endtask

	initial begin
		int err0;
		int pause_at;
		int pause_len;
		void'($urandom(32'hb9ac_5f10));
		reset <= 1'b1;
		dl_wr <= 1'b0;
		dl_active <= 1'b0;
		dl_addr <= '0;
		dl_data <= '0;
		dl_index <= '0;
		tape_motor <= 1'b0;
		tape_rewind <= 1'b0;
		tape_volume <= '0;
		stereo_mode <= '0;
		psg_a <= '0;
		psg_b <= '0;
		psg_c <= '0;
		// Nonzero mono mix, so only reset keeps the outputs at 0
		psg_mono <= '1;
		for (int i = 0; i < n_bytes; i++) begin
			tape_data[i] = oric_tape_pkg::tape_byte_t'($urandom);
			other_data[i] = oric_tape_pkg::tape_byte_t'($urandom);
		end
		for (int i = 0; i < n_rows; i++) build_row(i);
		pause_at = 1 + $urandom % (n_bits - 2);
		pause_len = 1 + $urandom % max_pause;

		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		err0 = n_errors;
		check_bit("tape_loaded", 1'b0, tape_loaded);
		check_bit("tape_bit", 1'b0, tape_bit);
		check_word("audio_l", '0, audio_l);
		check_word("audio_r", '0, audio_r);
		report_test("reset state", err0);

		err0 = n_errors;
		run_download(8'd2, 1'b0);
		run_download(oric_tape_pkg::tape_index, 1'b1);
		report_test("download", err0);

		err0 = n_errors;
		play_stream(0, 0);
		report_test("playback", err0);

		err0 = n_errors;
		rewind_tape();
		play_stream(pause_at, pause_len);
		report_test("pause and rewind", err0);

		// Mixer rows run over a fresh stream
		err0 = n_errors;
		rewind_tape();
		@(posedge clk_sys);
		tape_motor <= 1'b1;
		for (int i = 0; i < n_rows; i++) apply_row(i);
		report_test("mixer table", err0);

		$display("Checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: build.f
design/oric_tape_pkg.sv
design/tape_store_if.sv
design/tape_loader.sv
design/tape_player.sv
design/audio_mixer.sv
design/oric_tape_audio.sv
bench/oric_tape_audio_assertions.sv
bench/oric_tape_audio_tb.sv

// File: Makefile
# Verilator lint and simulation for the Oric tape and audio core

VERILATOR ?= verilator
FILELIST ?= build.f
TB_TOP ?= oric_tape_audio_tb
RTL_TOP ?= oric_tape_audio
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST OK" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
